// File: include/finder_params.svh
// finder parameters
// bus widths, memory depth and the codes that end a link chain or a token
`ifndef FINDER_PARAMS_SVH
`define FINDER_PARAMS_SVH

// data path and address path
`define DATA_W 8
`define ADDR_W 16

// bytes held by the dictionary memory
`define MEM_DEPTH 4096

// link value of the oldest header
`define NULL_LINK {`ADDR_W{1'b1}}

// token delimiter in the TIB
`define SPACE_CHAR 8'h20

`endif

// File: logic/finder_pkg.sv
// finder package
// byte and address types plus the word finder state encoding
`include "finder_params.svh"

package finder_pkg;

    typedef logic [`DATA_W-1:0] byte_t;      // one memory byte
    typedef logic [`ADDR_W-1:0] addr_t;      // address, link or tib pointer

    typedef enum logic [3:0] {
        IDLE,                                // wait for start
        SKIP,                                // leading space test
        LINK_LO,                             // link low byte
        LINK_HI,                             // link high byte
        LENGTH,                              // name length
        NAME_RD,                             // fetch one name byte
        TIB_RD,                              // fetch one tib byte
        COMPARE,                             // name vs tib
        TERM_RD,                             // fetch byte after the name
        TERM_CHK                             // must be a space
    } finder_state_e;

endpackage

// File: logic/dict_loader.sv
// dictionary loader
// turns a base strobe and byte strobes into memory writes at rising addresses
`timescale 1ns/1ps

module dict_loader import finder_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  load_begin,                // set pointer to load_base
    input  addr_t load_base,
    input  logic  load_strobe,               // one byte per strobe
    input  byte_t load_byte,
    output logic  wr_en,
    output addr_t wr_addr,
    output byte_t wr_data
);

    addr_t load_ptr;                         // next write address

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en    <= 1'b0;
            load_ptr <= '0;
        end else begin
            wr_en <= load_strobe;            // write follows strobe by one cycle
            if (load_begin) begin
                load_ptr <= load_base;
            end else if (load_strobe) begin
                load_ptr <= load_ptr + 1'b1; // auto increment
            end
        end
    end

    // write address and data
    always_ff @(posedge clk) begin
        if (load_strobe) begin
            wr_addr <= load_ptr;
            wr_data <= load_byte;
        end
    end

    // base and data strobes are separate steps of a load
    a_begin_strobe_excl: assert property (
        @(posedge clk) disable iff (reset) !(load_begin && load_strobe)
    ) else $error("load_begin and load_strobe high together");

endmodule

// File: logic/dict_mem.sv
// dictionary memory
// byte array with registered read, shared by loader and word finder
`timescale 1ns/1ps
`include "finder_params.svh"

module dict_mem import finder_pkg::*; #(
    parameter int DEPTH = `MEM_DEPTH         // bytes
) (
    input  logic  clk,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  byte_t wr_data,
    input  addr_t rd_addr,
    output byte_t rd_data
);

    localparam int IDX_W = $clog2(DEPTH);    // array index bits

    byte_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[IDX_W-1:0]] <= wr_data;    // write wins the port
        end
        rd_data <= mem[rd_addr[IDX_W-1:0]];        // old data on collision
    end

    // upper address bits are dropped by the index, so they must be zero
    a_wr_in_range: assert property (
        @(posedge clk) wr_en |-> (wr_addr < DEPTH)
    ) else $error("write address %h beyond memory", wr_addr);

    a_rd_in_range: assert property (
        @(posedge clk) !$isunknown(rd_addr) |-> (rd_addr < DEPTH)
    ) else $error("read address %h beyond memory", rd_addr);

endmodule

// File: logic/word_finder.sv
// forth word finder
// skips leading spaces, walks the link chain newest to oldest and matches
// each header name against the tib token
`timescale 1ns/1ps
`include "finder_params.svh"

module word_finder import finder_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  find_start,                // one cycle, taken in IDLE only
    input  addr_t tib_addr,
    input  addr_t context_addr,              // newest header
    output addr_t rd_addr,
    input  byte_t rd_data,                   // data of last cycle's rd_addr
    output logic  busy,
    output logic  done,
    output logic  found,
    output addr_t word_addr,
    output addr_t next_tib
);

    localparam addr_t NAME_OFS = addr_t'(3); // two link bytes + length

    finder_state_e state, next_state;

    addr_t hdr_ptr;                          // current link field address
    addr_t link;                             // link of current header
    byte_t link_lo;
    addr_t name_ptr;                         // current name byte
    addr_t name_end;                         // name start + length
    addr_t tib_ptr;
    addr_t tok_start;                        // token start after space skip
    byte_t name_byte;                        // name byte under compare
    logic  skip_wait;                        // rd_data stale after a skip

    logic  is_space;
    logic  byte_match;
    logic  last_byte;
    logic  end_of_chain;
    logic  start_ok;
    logic  hit;
    logic  finish;

    assign is_space     = (rd_data == `SPACE_CHAR);
    assign byte_match   = (rd_data == name_byte);
    assign last_byte    = ((name_ptr + 1'b1) == name_end);
    assign end_of_chain = (link == `NULL_LINK);
    assign start_ok     = (state == IDLE) && find_start;
    assign hit          = (state == TERM_CHK) && is_space;
    assign finish       = (state != IDLE) && (next_state == IDLE);

    // state register
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // next state
    always_comb begin
        case (state)
            IDLE:     next_state = find_start ? SKIP : IDLE;
            SKIP:     next_state = (!skip_wait && !is_space) ? LINK_LO : SKIP;
            LINK_LO:  next_state = LINK_HI;
            LINK_HI:  next_state = LENGTH;
            LENGTH:   next_state = (rd_data == '0) ? TERM_RD : NAME_RD; // empty name
            NAME_RD:  next_state = TIB_RD;
            TIB_RD:   next_state = COMPARE;
            COMPARE: begin
                if (!byte_match) begin
                    next_state = end_of_chain ? IDLE : LINK_LO;   // miss or next word
                end else begin
                    next_state = last_byte ? TERM_RD : NAME_RD;
                end
            end
            TERM_RD:  next_state = TERM_CHK;
            TERM_CHK: begin
                if (is_space || end_of_chain) begin
                    next_state = IDLE;       // hit, or prefix only on the last word
                end else begin
                    next_state = LINK_LO;
                end
            end
            default:  next_state = IDLE;
        endcase
    end

    // memory address, one request per cycle
    always_comb begin
        case (state)
            IDLE:     rd_addr = tib_addr;                      // first tib byte
            SKIP:     rd_addr = skip_wait ? tib_ptr : hdr_ptr;
            LINK_LO:  rd_addr = hdr_ptr + addr_t'(1);
            LINK_HI:  rd_addr = hdr_ptr + addr_t'(2);          // length byte
            LENGTH:   rd_addr = hdr_ptr + NAME_OFS;
            NAME_RD:  rd_addr = name_ptr;
            TIB_RD:   rd_addr = tib_ptr;
            COMPARE:  rd_addr = end_of_chain ? hdr_ptr : link; // next header on a mismatch
            TERM_RD:  rd_addr = tib_ptr;
            TERM_CHK: rd_addr = end_of_chain ? hdr_ptr : link;
            default:  rd_addr = tib_addr;
        endcase
    end

    // pointers and captured bytes
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (find_start) begin
                    tib_ptr <= tib_addr;
                    hdr_ptr <= context_addr;
                end
            end
            SKIP: begin
                if (!skip_wait && is_space) begin
                    tib_ptr <= tib_ptr + 1'b1;   // past one space
                end else if (!skip_wait) begin
                    tok_start <= tib_ptr;
                end
            end
            LINK_LO: link_lo <= rd_data;
            LINK_HI: link    <= {rd_data, link_lo};  // little endian link
            LENGTH: begin
                name_ptr <= hdr_ptr + NAME_OFS;
                name_end <= hdr_ptr + NAME_OFS + addr_t'(rd_data);
                tib_ptr  <= tok_start;           // compare restarts at token
            end
            TIB_RD: name_byte <= rd_data;
            COMPARE: begin
                if (byte_match) begin
                    name_ptr <= name_ptr + 1'b1;
                    tib_ptr  <= tib_ptr + 1'b1;
                end else if (!end_of_chain) begin
                    hdr_ptr <= link;
                end
            end
            TERM_CHK: begin
                if (!is_space && !end_of_chain) begin
                    hdr_ptr <= link;
                end
            end
            default: ;
        endcase
    end

    // control and results
    always_ff @(posedge clk) begin
        if (reset) begin
            skip_wait <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            found     <= 1'b0;
        end else begin
            skip_wait <= (state == SKIP) && !skip_wait && is_space;
            busy      <= (next_state != IDLE);
            done      <= finish;             // falls with busy
            if (start_ok) begin
                found <= 1'b0;
            end else if (finish) begin
                found <= hit;
            end
        end
    end

    // results held until the next search ends
    always_ff @(posedge clk) begin
        if (finish) begin
            word_addr <= hit ? hdr_ptr : `NULL_LINK;
            next_tib  <= hit ? tib_ptr : tok_start;   // terminator or token start
        end
    end

    a_done_after_busy: assert property (
        @(posedge clk) disable iff (reset) done |-> $past(busy)
    ) else $error("done without a search in progress");

    a_state_legal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {IDLE, SKIP, LINK_LO, LINK_HI, LENGTH,
                      NAME_RD, TIB_RD, COMPARE, TERM_RD, TERM_CHK}
    ) else $error("finder state out of range");

endmodule

// File: logic/forth_find_top.sv
// forth dictionary search top
// loader and word finder share the single byte memory port
`timescale 1ns/1ps
`include "finder_params.svh"

module forth_find_top import finder_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  load_begin,
    input  addr_t load_base,
    input  logic  load_strobe,
    input  byte_t load_byte,
    input  logic  find_start,
    input  addr_t tib_addr,
    input  addr_t context_addr,
    output logic  busy,
    output logic  done,
    output logic  found,
    output addr_t word_addr,
    output addr_t next_tib
);

    logic  wr_en;
    addr_t wr_addr;
    byte_t wr_data;
    addr_t fnd_rd_addr;                      // finder request
    addr_t port_addr;                        // shared port address
    byte_t rd_data;

    dict_loader i_loader (
        .clk         (clk),
        .reset       (reset),
        .load_begin  (load_begin),
        .load_base   (load_base),
        .load_strobe (load_strobe),
        .load_byte   (load_byte),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    // write owns the port, finder reads otherwise
    assign port_addr = wr_en ? wr_addr : fnd_rd_addr;

    dict_mem #(.DEPTH(`MEM_DEPTH)) i_mem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (port_addr),
        .rd_data (rd_data)
    );

    word_finder i_finder (
        .clk          (clk),
        .reset        (reset),
        .find_start   (find_start),
        .tib_addr     (tib_addr),
        .context_addr (context_addr),
        .rd_addr      (fnd_rd_addr),
        .rd_data      (rd_data),
        .busy         (busy),
        .done         (done),
        .found        (found),
        .word_addr    (word_addr),
        .next_tib     (next_tib)
    );

    // a load during a search would steal the finder's read slot
    a_no_write_while_busy: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> !busy
    ) else $error("memory write during a search");

endmodule

// File: verif/tb_forth_find.sv
// testbench for the forth dictionary search
// loads five headers and a tib, then runs a table of searches against the finder
`timescale 1ns/1ps
`include "finder_params.svh"

module tb_forth_find import finder_pkg::*; ();

    localparam addr_t DICT_BASE = addr_t'(16'h0100);
    localparam addr_t TIB_BASE  = addr_t'(16'h0800);

    logic  clk;
    logic  reset;
    logic  load_begin;
    addr_t load_base;
    logic  load_strobe;
    byte_t load_byte;
    logic  find_start;
    addr_t tib_addr;
    addr_t context_addr;
    logic  busy;
    logic  done;
    logic  found;
    addr_t word_addr;
    addr_t next_tib;

    // oldest first with each header linking back to the one before
    string dict_names [5] = '{"DUP", "DROP", "SWAP", "OVER", "DO"};
    string tib_text = "SWAP DUP ROT    OVER DRO DOX DO ";

    byte_t dict_bytes [$];
    byte_t tib_bytes [$];

    // search table
    string s_name [$];
    addr_t s_tib [$];
    addr_t s_ctx [$];
    logic  s_found [$];
    addr_t s_word [$];
    addr_t s_next [$];
    logic  s_restart [$];                   // second start while busy

    int error_count;
    int check_count;
    int cycle_count;
    int cycle_limit;

    forth_find_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .load_begin   (load_begin),
        .load_base    (load_base),
        .load_strobe  (load_strobe),
        .load_byte    (load_byte),
        .find_start   (find_start),
        .tib_addr     (tib_addr),
        .context_addr (context_addr),
        .busy         (busy),
        .done         (done),
        .found        (found),
        .word_addr    (word_addr),
        .next_tib     (next_tib)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;             // 40 ns period
    end

    // header address from the name lengths, 3 + len bytes per header
    function automatic addr_t hdr_addr(input int idx);
        addr_t a;
        a = DICT_BASE;
        for (int j = 0; j < idx; j++) begin
            a = a + addr_t'(3 + dict_names[j].len());
        end
        return a;
    endfunction

    task automatic build_streams();
        addr_t link;
        for (int i = 0; i < 5; i++) begin
            link = (i == 0) ? `NULL_LINK : hdr_addr(i - 1);
            dict_bytes.push_back(link[7:0]);    // little endian link
            dict_bytes.push_back(link[15:8]);
            dict_bytes.push_back(byte_t'(dict_names[i].len()));
            for (int k = 0; k < dict_names[i].len(); k++) begin
                dict_bytes.push_back(byte_t'(dict_names[i][k]));
            end
        end
        for (int k = 0; k < tib_text.len(); k++) begin
            tib_bytes.push_back(byte_t'(tib_text[k]));
        end
    endtask

    // expected results from the header layout and the token match
    task automatic add_search(input string name, input int tib_off, input int lead,
                              input int tok_len, input int ctx_idx, input int hit_idx,
                              input logic restart);
        logic hit;
        hit = (hit_idx >= 0);
        s_name.push_back(name);
        s_tib.push_back(TIB_BASE + addr_t'(tib_off));
        s_ctx.push_back(hdr_addr(ctx_idx));
        s_found.push_back(hit);
        s_word.push_back(hit ? hdr_addr(hit_idx) : `NULL_LINK);
        s_next.push_back(TIB_BASE + addr_t'(tib_off + lead + (hit ? tok_len : 0)));
        s_restart.push_back(restart);
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: expected %b, got %b", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic load_block(input addr_t base, input byte_t data [$]);
        load_begin = 1'b1;                  // set the loader pointer
        load_base  = base;
        @(negedge clk);
        load_begin = 1'b0;
        foreach (data[i]) begin
            load_strobe = 1'b1;
            load_byte   = data[i];
            @(negedge clk);
        end
        load_strobe = 1'b0;
        repeat (2) @(negedge clk);          // last write lands
    endtask

    task automatic run_search(input int idx);
        find_start   = 1'b1;
        tib_addr     = s_tib[idx];
        context_addr = s_ctx[idx];
        @(negedge clk);
        find_start = 1'b0;
        if (s_restart[idx]) begin
            check_flag({s_name[idx], " busy"}, 1'b1, busy);
            find_start = 1'b1;              // must be ignored
            tib_addr   = TIB_BASE + addr_t'(5);
            @(negedge clk);
            find_start = 1'b0;
        end
        while (!done) begin
            @(negedge clk);
        end
        check_flag({s_name[idx], " found"}, s_found[idx], found);
        check_addr({s_name[idx], " word_addr"}, s_word[idx], word_addr);
        check_addr({s_name[idx], " next_tib"}, s_next[idx], next_tib);
        check_flag({s_name[idx], " busy at done"}, 1'b0, busy);
        @(negedge clk);
        check_flag({s_name[idx], " done pulse"}, 1'b0, done);
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        reset        = 1'b1;
        load_begin   = 1'b0;
        load_base    = '0;
        load_strobe  = 1'b0;
        load_byte    = '0;
        find_start   = 1'b0;
        tib_addr     = '0;
        context_addr = '0;
        error_count  = 0;
        check_count  = 0;
        cycle_count  = 0;

        build_streams();
        add_search("swap_hit",         0,  0, 4, 4,  2, 1'b0);
        add_search("dup_hit",          5,  0, 3, 4,  0, 1'b0);
        add_search("rot_miss",         9,  0, 3, 4, -1, 1'b0);
        add_search("lead_spaces",      13, 3, 4, 4,  3, 1'b0);
        add_search("dro_no_prefix",    21, 0, 3, 4, -1, 1'b0);
        add_search("dox_bad_term",     25, 0, 3, 4, -1, 1'b0);
        add_search("do_hit",           29, 0, 2, 4,  4, 1'b0);
        add_search("over_old_context", 13, 3, 4, 1, -1, 1'b0);
        add_search("start_while_busy", 0,  0, 4, 4,  2, 1'b1);

        // reset + two loads, then worst case walk of every header per search
        cycle_limit = 2 + 6 + dict_bytes.size() + tib_bytes.size()
                    + s_name.size() * (3 * dict_bytes.size() + 2 * tib_bytes.size())
                    + 100;

        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_flag("reset busy", 1'b0, busy);
        check_flag("reset done", 1'b0, done);
        check_flag("reset found", 1'b0, found);

        load_block(DICT_BASE, dict_bytes);
        load_block(TIB_BASE, tib_bytes);

        for (int i = 0; i < s_name.size(); i++) begin
            run_search(i);
        end

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
logic/finder_pkg.sv
logic/dict_loader.sv
logic/dict_mem.sv
logic/word_finder.sv
logic/forth_find_top.sv
verif/tb_forth_find.sv

// File: Makefile
# Verilator build and run for the forth dictionary search

TOP := tb_forth_find

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
